// File: logic/async_reset_sync.sv
`timescale 1ns/1ns
`default_nettype none

// Reset for one design, asserted at once and released after two clock edges
module async_reset_sync (
    input  wire  clk,
    input  wire  asyncrst_n,   // Gated reset, low holds the design
    output logic n_rst         // Synchronized reset to the design
);

    logic sync_ff;             // First stage, settles metastability

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            sync_ff <= 1'b0;
            n_rst   <= 1'b0;
        end else begin
            sync_ff <= 1'b1;
            n_rst   <= sync_ff;    // High on the second edge after release
        end
    end

endmodule

`default_nettype wire

// File: logic/design_harness_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_params.svh"

module design_harness_top
    import harness_pkg::*;
(
    input  wire                              clk,
    input  wire                              asyncrst_n,     // Chip reset
    input  wire                              sel_wr,         // Host write strobe
    input  wire design_id_t                  sel_data,       // Host design number
    input  wire [`NUM_DESIGNS*`IO_WIDTH-1:0] designs_io,     // Outputs of all designs
    output wire io_word_t                    io_out,         // Active design's word
    output wire design_mask_t                designs_n_rst,  // Resets to the designs
    output wire                              sel_error       // Bad design number written
);

    design_mask_t designs_cs;          // Decoder to router
    design_id_t   active_id;           // Decoder to output mux

    // Decode stage
    design_select_decoder i_design_select_decoder (
        .clk        (clk),
        .asyncrst_n (asyncrst_n),
        .sel_wr     (sel_wr),
        .sel_data   (sel_data),
        .active_id  (active_id),
        .designs_cs (designs_cs),
        .sel_error  (sel_error)
    );

    // Execute stage
    reset_router i_reset_router (
        .clk           (clk),
        .asyncrst_n    (asyncrst_n),
        .designs_cs    (designs_cs),
        .designs_n_rst (designs_n_rst)
    );

    // Result stage, waits for the routed reset before driving the pins
    output_mux i_output_mux (
        .clk           (clk),
        .asyncrst_n    (asyncrst_n),
        .active_id     (active_id),
        .designs_n_rst (designs_n_rst),
        .designs_io    (designs_io),
        .io_out        (io_out)
    );

endmodule

`default_nettype wire

// File: logic/design_select_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_params.svh"

module design_select_decoder
    import harness_pkg::*;
(
    input  wire             clk,
    input  wire             asyncrst_n,
    input  wire             sel_wr,       // One-cycle write strobe from the host
    input  wire design_id_t sel_data,     // Requested design number
    output design_id_t      active_id,    // Currently selected design, 0 is none
    output design_mask_t    designs_cs,   // Set bit holds that design in reset
    output logic            sel_error     // Pulses for one cycle after a bad write
);

    design_id_t   id_next;
    logic         error_next;
    design_mask_t cs_next;

    // Range check of the host write
    always_comb begin
        id_next    = active_id;
        error_next = 1'b0;
        if (sel_wr) begin
            if (sel_data <= design_id_t'(`NUM_DESIGNS)) begin
                id_next = sel_data;
            end else begin
                error_next = 1'b1;      // 13 to 15 name no design
            end
        end
    end

    // Every design is held except the one about to become active
    // With id_next of 0 no bit is cleared, so all designs stay held
    always_comb begin
        cs_next = '1;
        for (int i = 1; i <= `NUM_DESIGNS; i++) begin
            if (id_next == design_id_t'(i)) begin
                cs_next[i] = 1'b0;
            end
        end
    end

    // The mask is registered together with the number, so both change on the write edge
    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            active_id  <= '0;
            designs_cs <= '1;           // No design selected out of reset
            sel_error  <= 1'b0;
        end else begin
            active_id  <= id_next;
            designs_cs <= cs_next;
            sel_error  <= error_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/harness_params.svh
`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// Number of user designs on the chip, numbered 1 to NUM_DESIGNS
`define NUM_DESIGNS 12

// Width of one design's output word on the chip pins
`define IO_WIDTH 8

// Width of a design number, large enough for 0 to NUM_DESIGNS
`define SEL_WIDTH 4

`endif

// File: logic/harness_pkg.sv
`default_nettype none

`include "harness_params.svh"

package harness_pkg;

    // Design number, 0 selects no design
    typedef logic [`SEL_WIDTH-1:0] design_id_t;

    // One bit per design, bit i belongs to design i
    typedef logic [`NUM_DESIGNS:1] design_mask_t;

    // Output word of a single design
    typedef logic [`IO_WIDTH-1:0] io_word_t;

endpackage

`default_nettype wire

// File: logic/output_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_params.svh"

module output_mux
    import harness_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  asyncrst_n,
    input  wire design_id_t                      active_id,      // Selected design, 0 is none
    input  wire design_mask_t                    designs_n_rst,  // Per-design reset state
    // Design i drives bits [(i-1)*IO_WIDTH +: IO_WIDTH]
    input  wire [`NUM_DESIGNS*`IO_WIDTH-1:0]     designs_io,
    output io_word_t                             io_out          // Word on the chip pins
);

    io_word_t design_words [1:`NUM_DESIGNS];   // Flat input split into words
    io_word_t word_next;

    // Split the flat bus into one word per design
    always_comb begin
        for (int i = 1; i <= `NUM_DESIGNS; i++) begin
            design_words[i] = designs_io[(i-1)*`IO_WIDTH +: `IO_WIDTH];
        end
    end

    // Pass the active word only once its design has left reset
    // active_id of 0 matches no design and leaves the pins at zero
    always_comb begin
        word_next = '0;
        for (int i = 1; i <= `NUM_DESIGNS; i++) begin
            if (active_id == design_id_t'(i) && designs_n_rst[i]) begin
                word_next = design_words[i];
            end
        end
    end

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            io_out <= '0;
        end else begin
            io_out <= word_next;       // One cycle behind the design
        end
    end

endmodule

`default_nettype wire

// File: logic/reset_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_params.svh"

module reset_router
    import harness_pkg::*;
(
    input  wire               clk,
    input  wire               asyncrst_n,     // Chip reset
    input  wire design_mask_t designs_cs,     // Set bit holds that design in reset
    output wire design_mask_t designs_n_rst   // Per-design reset, active low
);

    design_mask_t cs_n_rst;                   // Gated reset ahead of each synchronizer

    // One synchronizer per design
    // A design is held whenever the chip is in reset or it is not selected
    for (genvar i = 1; i <= `NUM_DESIGNS; i++) begin : g_design

        assign cs_n_rst[i] = asyncrst_n & ~designs_cs[i];

        async_reset_sync i_async_reset_sync (
            .clk        (clk),
            .asyncrst_n (cs_n_rst[i]),
            .n_rst      (designs_n_rst[i])
        );

    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/harness_pkg.sv
logic/design_select_decoder.sv
logic/async_reset_sync.sv
logic/reset_router.sv
logic/output_mux.sv
logic/design_harness_top.sv
verification/tb_clock_gen.sv
verification/tb_design_harness.sv

// File: verification/harness_vectors.txt
// Columns (hex): test asyncrst_n sel_wr sel_data base | io_out designs_n_rst sel_error
// Design i sees base ^ i on its output word; expected values are sampled after the edge

// Test 1: reset held for 4 cycles, then idle with no write
1 0 0 0 a3 00 000 0
1 0 0 0 5c 00 000 0
1 0 0 0 e1 00 000 0
1 0 0 0 17 00 000 0
1 1 0 0 68 00 000 0
1 1 0 5 b2 00 000 0
1 1 0 0 4d 00 000 0

// Test 2: select design 3, reset bit 3 at N+2, word at N+3
2 1 1 3 5a 00 000 0
2 1 0 0 11 00 000 0
2 1 0 0 22 00 004 0
2 1 0 0 3c 3f 004 0
2 1 0 0 a5 a6 004 0
2 1 0 0 70 73 004 0

// Test 3: switch from 3 to 7, old word still registered at edge N
3 1 1 7 81 82 000 0
3 1 0 0 44 00 000 0
3 1 0 0 9e 00 040 0
3 1 0 0 c3 c4 040 0
3 1 0 0 0f 08 040 0

// Test 4: numbers 14 and 13 are rejected, then 0 deselects all
4 1 1 e 55 52 040 1
4 1 0 0 66 61 040 0
4 1 1 d 2b 2c 040 1
4 1 0 0 3d 3a 040 0
4 1 1 0 90 97 000 0
4 1 0 0 18 00 000 0
4 1 0 0 e7 00 000 0

// Test 5: run design 12, chip reset with a pending error, recover with design 1
5 1 1 c 01 00 000 0
5 1 0 0 02 00 000 0
5 1 0 0 03 00 800 0
5 1 0 0 04 08 800 0
5 1 1 f 05 09 800 1
5 0 0 0 06 00 000 0
5 0 0 0 07 00 000 0
5 1 0 0 08 00 000 0
5 1 0 0 09 00 000 0
5 1 0 0 0a 00 000 0
5 1 1 1 10 00 000 0
5 1 0 0 20 00 000 0
5 1 0 0 30 00 001 0
5 1 0 0 40 41 001 0
5 1 0 0 50 51 001 0

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running clock for the testbench
module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                        // First rising edge after half a period
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_design_harness.sv
`timescale 1ns/1ns
`default_nettype none

`include "harness_params.svh"

module tb_design_harness
    import harness_pkg::*;
();

    localparam int FIELDS      = 8;                           // Columns per vector line
    localparam int MAX_VECTORS = 256;
    localparam int IO_BITS     = `NUM_DESIGNS * `IO_WIDTH;

    // Column positions within one vector line
    localparam int F_TEST  = 0;
    localparam int F_RST_N = 1;
    localparam int F_WR    = 2;
    localparam int F_DATA  = 3;
    localparam int F_BASE  = 4;
    localparam int F_IO    = 5;
    localparam int F_N_RST = 6;
    localparam int F_ERROR = 7;

    logic               clk;
    logic               asyncrst_n;
    logic               sel_wr;
    design_id_t         sel_data;
    logic [IO_BITS-1:0] designs_io;
    io_word_t           io_out;
    design_mask_t       designs_n_rst;
    logic               sel_error;

    logic [31:0] vec_mem [0:MAX_VECTORS*FIELDS-1];            // One token per entry

    int num_vectors   = 0;
    int timeout_limit = MAX_VECTORS + 20;                     // Tightened once the file is read
    int cycle_count   = 0;
    int error_count   = 0;
    int test_errors   = 0;                                    // Failed checks of the running test
    int test_vectors  = 0;
    int tests_passed  = 0;
    int tests_failed  = 0;

    tb_clock_gen #(
        .PERIOD_NS (10)
    ) i_tb_clock_gen (
        .clk (clk)
    );

    design_harness_top i_design_harness_top (
        .clk           (clk),
        .asyncrst_n    (asyncrst_n),
        .sel_wr        (sel_wr),
        .sel_data      (sel_data),
        .designs_io    (designs_io),
        .io_out        (io_out),
        .designs_n_rst (designs_n_rst),
        .sel_error     (sel_error)
    );

    function automatic logic [31:0] field(input int v, input int f);
        return vec_mem[v*FIELDS + f];
    endfunction

    // Design i drives the base byte with its own number XORed in
    function automatic logic [IO_BITS-1:0] spread_base(input io_word_t base);
        logic [IO_BITS-1:0] flat;
        flat = '0;
        for (int i = 1; i <= `NUM_DESIGNS; i++) begin
            flat[(i-1)*`IO_WIDTH +: `IO_WIDTH] = base ^ io_word_t'(i);
        end
        return flat;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset and idle";
            2:       return "select design 3";
            3:       return "switch to design 7";
            4:       return "bad number and deselect";
            5:       return "chip reset in mid-run";
            default: return "unnamed";
        endcase
    endfunction

    task automatic load_vectors();
        int tokens;
        tokens = 0;
        $readmemh("verification/harness_vectors.txt", vec_mem);
        while (tokens < MAX_VECTORS*FIELDS && !$isunknown(vec_mem[tokens])) begin
            tokens++;
        end
        num_vectors = tokens / FIELDS;
        if (num_vectors == 0) begin
            $display("No vectors could be read from verification/harness_vectors.txt");
            error_count++;
        end
        if (tokens % FIELDS != 0) begin
            $display("The vector file ends with an incomplete line of %0d fields",
                     tokens % FIELDS);
            error_count++;
        end
    endtask

    task automatic apply_vector(input int v);
        asyncrst_n = 1'(field(v, F_RST_N));
        sel_wr     = 1'(field(v, F_WR));
        sel_data   = design_id_t'(field(v, F_DATA));
        designs_io = spread_base(io_word_t'(field(v, F_BASE)));
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("ERR time %0t ns, %s: expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int v);
        check_value("io_out", field(v, F_IO), io_out);
        check_value("designs_n_rst", field(v, F_N_RST), designs_n_rst);
        check_value("sel_error", field(v, F_ERROR), sel_error);
    endtask

    // Chip reset clears everything with no clock edge in between
    task automatic check_cleared();
        check_value("io_out", 32'h0, io_out);
        check_value("designs_n_rst", 32'h0, designs_n_rst);
        check_value("sel_error", 32'h0, sel_error);
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d (%s): pass, %0d vectors", id, test_name(id), test_vectors);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): fail, %0d errors in %0d vectors",
                     id, test_name(id), test_errors, test_vectors);
        end
        test_errors  = 0;
        test_vectors = 0;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        asyncrst_n = 1'b0;                 // Chip starts in reset
        sel_wr     = 1'b0;
        sel_data   = '0;
        designs_io = '0;

        load_vectors();
        timeout_limit = num_vectors + 20;

        for (int v = 0; v < num_vectors; v++) begin
            @(negedge clk);
            apply_vector(v);
            if (!asyncrst_n) begin
                #2;                        // Still ahead of the rising edge
                check_cleared();
            end
            @(posedge clk);
            #4;                            // Just before the next falling edge
            check_outputs(v);
            test_vectors++;
            if (v == num_vectors - 1 || field(v + 1, F_TEST) != field(v, F_TEST)) begin
                report_test(field(v, F_TEST));
            end
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
